// ==== Makefile ====
TOOL  = verilator
FLAGS = --binary --timing --assert -Wno-fatal
TOP   = snd_tb
FLIST = list.f
OBJ   = obj_dir
LOG   = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench, fails when the log reports errors"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ)
	./$(OBJ)/V$(TOP) | tee $(LOG)
	@if grep -q "Done: errors found" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@grep -q "Done: no errors" $(LOG) || (echo "simulation did not finish"; exit 1)

clean:
	rm -rf $(OBJ) $(LOG)

// ==== design/dc_blocker.sv ====
/*
 * DC blocker for the PCM level
 * subtracts a running average and gives a signed 8-bit sample
 */
`timescale 1ns/1ps

module dc_blocker import snd_pkg::*; (
    input  logic              clk,
    input  logic              comb_rstn,
    input  logic              pcm_step,
    input  pcm_byte_t         pcm_level,
    output logic signed [7:0] pcm_signed
);

    logic               step_d;
    logic signed [7:0]  x;
    logic signed [15:0] acc;
    logic signed [15:0] avg;
    logic signed [15:0] diff;

    // offset binary to two's complement
    assign x    = $signed(pcm_level - pcm_idle_level);
    assign avg  = acc >>> dc_shift;
    assign diff = x - avg;

    // level settles in the player on the step, so work one cycle later
    always_ff @(posedge clk or negedge comb_rstn) begin
        if (!comb_rstn) begin
            step_d     <= 1'b0;
            acc        <= '0;
            pcm_signed <= '0;
        end else begin
            step_d <= pcm_step;
            if (step_d) begin
                acc <= acc + x - avg;
                if (diff > 127) begin
                    pcm_signed <= 8'h7f;
                end else if (diff < -128) begin
                    pcm_signed <= 8'h80;
                end else begin
                    pcm_signed <= diff[7:0];
                end
            end
        end
    end

endmodule

// ==== design/mix_channel.sv ====
/*
 * mixer channel scaler
 * multiplies one aligned sample by its gain, unity at 16
 */
`timescale 1ns/1ps

module mix_channel import snd_pkg::*; (
    input  logic    clk,
    input  logic    comb_rstn,
    input  sample_t chan_in,
    input  gain_t   chan_gain,
    output chan_t   chan_out
);

    logic signed [8:0]  gain_s;
    logic signed [24:0] product;

    // gain is unsigned, keep it positive in the signed multiply
    assign gain_s  = $signed({1'b0, chan_gain});
    assign product = chan_in * gain_s;

    always_ff @(posedge clk or negedge comb_rstn) begin
        if (!comb_rstn) begin
            chan_out <= '0;
        end else begin
            // arithmetic shift by gain_shift
            chan_out <= product[gain_shift +: $bits(chan_t)];
        end
    end

endmodule

// ==== design/mix_source_select.sv ====
/*
 * mixer source select
 * picks the channel gains and aligns FM, PSG and PCM to 16-bit signed
 */
`timescale 1ns/1ps

module mix_source_select import snd_pkg::*; (
    input  logic              clk,
    input  logic              comb_rstn,
    input  sample_t           fm_snd,
    input  psg_t              psg_snd,
    input  logic signed [7:0] pcm_signed,
    input  logic [1:0]        fx_level,
    input  logic              fm_en,
    input  logic              psg_en,
    input  logic              pcm_board,
    output sample_t           chan_in [num_chan],
    output gain_t             chan_gain [num_chan]
);

    sample_t psg_aligned;
    sample_t pcm_aligned;

    // psg is unsigned around 512, flipping the msb centres it
    assign psg_aligned = {~psg_snd[9], psg_snd[8:0], 6'd0};
    assign pcm_aligned = {pcm_signed, 8'd0};

    always_ff @(posedge clk or negedge comb_rstn) begin
        if (!comb_rstn) begin
            for (int i = 0; i < num_chan; i++) begin
                chan_in[i]   <= '0;
                chan_gain[i] <= '0;
            end
        end else begin
            chan_in[chan_fm]  <= fm_snd;
            chan_in[chan_psg] <= psg_aligned;
            chan_in[chan_pcm] <= pcm_aligned;

            if (!fm_en) begin
                chan_gain[chan_fm] <= '0;
            end else if (pcm_board) begin
                chan_gain[chan_fm] <= gain_fm_pcm_board;
            end else begin
                chan_gain[chan_fm] <= gain_fm_std;
            end

            // effects level picks the psg loudness
            chan_gain[chan_psg] <= psg_en ? psg_gain_by_level[fx_level] : gain_t'(0);
            chan_gain[chan_pcm] <= pcm_board ? gain_pcm : gain_t'(0);
        end
    end

endmodule

// ==== design/mix_sum.sv ====
/*
 * mixer summing stage
 * adds the scaled channels and clamps to 16 bits, peak flags clipping
 */
`timescale 1ns/1ps

module mix_sum import snd_pkg::*; (
    input  logic    clk,
    input  logic    comb_rstn,
    input  logic    mix_cen,
    input  chan_t   chan_out [num_chan],
    output sample_t snd,
    output logic    peak
);

    // two guard bits cover three channels
    logic signed [$bits(chan_t)+1:0] total;

    always_comb begin
        total = '0;
        for (int i = 0; i < num_chan; i++) begin
            total = total + chan_out[i];
        end
    end

    always_ff @(posedge clk or negedge comb_rstn) begin
        if (!comb_rstn) begin
            snd  <= '0;
            peak <= 1'b0;
        end else if (mix_cen) begin
            if (total > 32767) begin
                snd  <= 16'sh7fff;
                peak <= 1'b1;
            end else if (total < -32768) begin
                snd  <= 16'sh8000;
                peak <= 1'b1;
            end else begin
                snd  <= total[15:0];
                peak <= 1'b0;
            end
        end
    end

endmodule

// ==== design/pcm_player.sv ====
/*
 * PCM sample player
 * a rising edge on portb bit 7 looks up the sample start in the header
 * table, then one byte per step is streamed until a zero byte
 */
`timescale 1ns/1ps

module pcm_player import snd_pkg::*; (
    input  logic      clk,
    input  logic      comb_rstn,
    input  logic      sample,
    input  pcm_byte_t portb,
    input  pcm_byte_t pcm_data,
    input  logic      pcm_ok,
    output pcm_addr_t pcm_addr,
    output pcm_byte_t pcm_level,
    output logic      pcm_step
);

    logic                sample_l;
    logic                pb7_l;
    logic [rate_div-1:0] step_ring;
    pcm_state_e          state;
    pcm_byte_t           hdr_lsb;
    logic                trigger;
    logic                take;

    assign trigger = portb[7] & ~pb7_l;
    // a step without valid memory data is dropped
    assign take    = pcm_step & pcm_ok;

    // rate divider, one step every rate_div sample edges
    always_ff @(posedge clk or negedge comb_rstn) begin
        if (!comb_rstn) begin
            sample_l  <= 1'b0;
            step_ring <= {{(rate_div-1){1'b0}}, 1'b1};
            pcm_step  <= 1'b0;
        end else begin
            sample_l <= sample;
            pcm_step <= 1'b0;
            if (sample && !sample_l) begin
                step_ring <= {step_ring[rate_div-2:0], step_ring[rate_div-1]};
                pcm_step  <= step_ring[rate_div-1];
            end
        end
    end

    // low header byte, only meaningful in read_msb
    always_ff @(posedge clk) begin
        if (take && state == read_lsb) begin
            hdr_lsb <= pcm_data;
        end
    end

    always_ff @(posedge clk or negedge comb_rstn) begin
        if (!comb_rstn) begin
            pb7_l     <= 1'b0;
            state     <= idle;
            pcm_addr  <= '0;
            pcm_level <= pcm_idle_level;
        end else begin
            pb7_l <= portb[7];
            if (trigger) begin
                // two header bytes per entry
                state    <= read_lsb;
                pcm_addr <= pcm_table_base + {9'd0, portb[5:0], 1'b0};
            end else if (take) begin
                case (state)
                    read_lsb: begin
                        pcm_addr <= pcm_addr + 1'b1;
                        state    <= read_msb;
                    end
                    read_msb: begin
                        pcm_addr <= {pcm_data, hdr_lsb};
                        state    <= play;
                    end
                    play: begin
                        if (pcm_data == 8'd0 || (&pcm_addr)) begin
                            // end marker is not played
                            state     <= idle;
                            pcm_level <= pcm_idle_level;
                        end else begin
                            pcm_level <= pcm_data;
                        end
                        pcm_addr <= pcm_addr + 1'b1;
                    end
                    default: begin
                        state <= idle;
                    end
                endcase
            end
        end
    end

endmodule

// ==== design/snd_pkg.sv ====
/*
 * sound back end shared definitions
 * widths, channel indices, mixer gains and the PCM player states
 */
package snd_pkg;

    // audio and memory widths
    typedef logic signed [15:0] sample_t;
    typedef logic        [9:0]  psg_t;
    typedef logic        [7:0]  pcm_byte_t;
    typedef logic        [15:0] pcm_addr_t;
    typedef logic        [7:0]  gain_t;
    typedef logic signed [19:0] chan_t;

    // mixer channels
    localparam int num_chan = 3;
    localparam int chan_fm  = 0;
    localparam int chan_psg = 1;
    localparam int chan_pcm = 2;

    // sample memory header table and rest level
    localparam pcm_addr_t pcm_table_base = 16'h0090;
    localparam pcm_byte_t pcm_idle_level = 8'h80;

    // gains where 16 is unity
    localparam gain_t gain_fm_std       = 8'h30;
    localparam gain_t gain_fm_pcm_board = 8'h20;
    localparam gain_t gain_pcm          = 8'h0a;
    // indexed by effects level 0..3
    localparam logic [3:0][7:0] psg_gain_by_level = {8'd9, 8'd7, 8'd5, 8'd2};

    localparam int gain_shift = 4;
    localparam int dc_shift   = 4;
    localparam int rate_div   = 3;

    typedef enum logic [1:0] {idle, read_lsb, read_msb, play} pcm_state_e;

endpackage

// ==== design/snd_top.sv ====
/*
 * sound back end top level
 * PCM player and DC blocker feeding a three channel mixer with FM and PSG
 */
`timescale 1ns/1ps

module snd_top import snd_pkg::*; (
    input  logic       clk,
    input  logic       comb_rstn,
    input  logic       sample,
    input  logic       mix_cen,
    input  pcm_byte_t  portb,
    input  pcm_byte_t  pcm_data,
    input  logic       pcm_ok,
    input  sample_t    fm_snd,
    input  psg_t       psg_snd,
    input  logic [1:0] fx_level,
    input  logic       fm_en,
    input  logic       psg_en,
    input  logic       pcm_board,
    output pcm_addr_t  pcm_addr,
    output sample_t    snd,
    output logic       peak
);

    pcm_byte_t         pcm_level;
    logic              pcm_step;
    logic signed [7:0] pcm_signed;
    sample_t           chan_in [num_chan];
    gain_t             chan_gain [num_chan];
    chan_t             chan_out [num_chan];

    pcm_player u_player (
        .clk       (clk),
        .comb_rstn (comb_rstn),
        .sample    (sample),
        .portb     (portb),
        .pcm_data  (pcm_data),
        .pcm_ok    (pcm_ok),
        .pcm_addr  (pcm_addr),
        .pcm_level (pcm_level),
        .pcm_step  (pcm_step)
    );

    dc_blocker u_dcrm (
        .clk        (clk),
        .comb_rstn  (comb_rstn),
        .pcm_step   (pcm_step),
        .pcm_level  (pcm_level),
        .pcm_signed (pcm_signed)
    );

    mix_source_select u_select (
        .clk        (clk),
        .comb_rstn  (comb_rstn),
        .fm_snd     (fm_snd),
        .psg_snd    (psg_snd),
        .pcm_signed (pcm_signed),
        .fx_level   (fx_level),
        .fm_en      (fm_en),
        .psg_en     (psg_en),
        .pcm_board  (pcm_board),
        .chan_in    (chan_in),
        .chan_gain  (chan_gain)
    );

    // one scaler per channel
    for (genvar i = 0; i < num_chan; i++) begin : g_chan
        mix_channel u_chan (
            .clk       (clk),
            .comb_rstn (comb_rstn),
            .chan_in   (chan_in[i]),
            .chan_gain (chan_gain[i]),
            .chan_out  (chan_out[i])
        );
    end

    mix_sum u_sum (
        .clk       (clk),
        .comb_rstn (comb_rstn),
        .mix_cen   (mix_cen),
        .chan_out  (chan_out),
        .snd       (snd),
        .peak      (peak)
    );

endmodule

// ==== list.f ====
design/snd_pkg.sv
design/pcm_player.sv
design/dc_blocker.sv
design/mix_source_select.sv
design/mix_channel.sv
design/mix_sum.sv
design/snd_top.sv
tests/snd_assertions.sv
tests/snd_tb.sv

// ==== tests/snd_assertions.sv ====
/*
 * sound back end assertions
 * peak known, snd moves only after mix_cen, pcm_addr held between steps
 */
`timescale 1ns/1ps

module snd_assertions import snd_pkg::*; (
    input logic      clk,
    input logic      comb_rstn,
    input logic      mix_cen,
    input pcm_byte_t portb,
    input logic      pcm_step,
    input pcm_addr_t pcm_addr,
    input sample_t   snd,
    input logic      peak
);

    peak_known: assert property (@(posedge clk) disable iff (!comb_rstn)
        !$isunknown(peak))
        else $error("peak is unknown");

    snd_on_mix_cen: assert property (@(posedge clk) disable iff (!comb_rstn)
        !mix_cen |=> $stable(snd))
        else $error("snd changed without mix_cen");

    // address moves only on a step or a trigger edge
    addr_hold: assert property (@(posedge clk) disable iff (!comb_rstn)
        (!pcm_step && !$rose(portb[7])) |=> $stable(pcm_addr))
        else $error("pcm_addr changed without step or trigger");

endmodule

bind snd_top snd_assertions i_asrt (
    .clk       (clk),
    .comb_rstn (comb_rstn),
    .mix_cen   (mix_cen),
    .portb     (portb),
    .pcm_step  (pcm_step),
    .pcm_addr  (pcm_addr),
    .snd       (snd),
    .peak      (peak)
);

// ==== tests/snd_tb.sv ====
/*
 * sound back end testbench
 * runs the vectors of the tests file against snd_top with a sample memory model
 */
`timescale 1ns/1ps

module snd_tb import snd_pkg::*;;

    logic       clk;
    logic       comb_rstn;
    logic       sample;
    logic       mix_cen;
    pcm_byte_t  portb;
    pcm_byte_t  pcm_data;
    logic       pcm_ok;
    sample_t    fm_snd;
    psg_t       psg_snd;
    logic [1:0] fx_level;
    logic       fm_en;
    logic       psg_en;
    logic       pcm_board;
    pcm_addr_t  pcm_addr;
    sample_t    snd;
    logic       peak;

    logic [7:0]  mem [65536];
    string       names [$];
    string       kinds [$];
    logic [31:0] f1 [$];
    logic [31:0] f2 [$];
    logic [31:0] f3 [$];
    logic [31:0] f4 [$];
    logic [31:0] f5 [$];
    logic [31:0] f6 [$];
    logic [31:0] e1 [$];
    logic [31:0] e2 [$];
    logic [31:0] rng = 32'd76;
    pcm_addr_t   last_addr;
    longint      limit_ns = 0;
    int          cyc = 0;

    snd_top i_dut (.*);

    // memory always answers the current address
    assign pcm_data = mem[pcm_addr];

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // mixer enable every fourth cycle, strobe toggles every eight
    always @(posedge clk) begin
        #1;
        cyc = cyc + 1;
        mix_cen = (cyc % 4 == 0);
        if (cyc % 8 == 0) sample = ~sample;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic apply_reset(output int fails);
        fails = 0;
        @(posedge clk);
        #1;
        comb_rstn = 1'b0;
        repeat (3) begin
            @(negedge clk);
            if (snd !== 16'd0 || peak !== 1'b0 || pcm_addr !== 16'd0) begin
                $display("reset: outputs not cleared while reset is held");
                fails++;
            end
        end
        @(posedge clk);
        #1;
        comb_rstn = 1'b1;
    endtask

    task automatic wait_addr_move(output bit moved);
        moved = 1'b0;
        for (int c = 0; c < 200 && !moved; c++) begin
            @(negedge clk);
            if (pcm_addr !== last_addr) moved = 1'b1;
        end
        last_addr = pcm_addr;
    endtask

    task automatic reset_state(input int t, output int fails);
        apply_reset(fails);
        repeat (2) @(negedge clk);
        if (snd !== e1[t][15:0]) begin
            $display("ERR %s: snd expected %h, got %h", names[t], e1[t][15:0], snd);
            fails++;
        end
        if (peak !== e2[t][0]) begin
            $display("ERR %s: peak expected %b, got %b", names[t], e2[t][0], peak);
            fails++;
        end
        if (pcm_addr !== 16'd0) begin
            $display("ERR %s: pcm_addr expected 0000, got %h", names[t], pcm_addr);
            fails++;
        end
    endtask

    task automatic mix_levels(input int t, output int fails);
        fails = 0;
        @(posedge clk);
        #1;
        fm_snd    = f1[t][15:0];
        psg_snd   = f2[t][9:0];
        fx_level  = f3[t][1:0];
        fm_en     = f4[t][0];
        psg_en    = f5[t][0];
        pcm_board = f6[t][0];
        portb     = 8'h00;
        // pipeline plus one mix period
        repeat (12) @(negedge clk);
        if (snd !== e1[t][15:0]) begin
            $display("ERR %s: snd expected %h, got %h", names[t], e1[t][15:0], snd);
            fails++;
        end
        if (peak !== e2[t][0]) begin
            $display("ERR %s: peak expected %b, got %b", names[t], e2[t][0], peak);
            fails++;
        end
    endtask

    task automatic sample_playback(input int t, output int fails);
        pcm_addr_t  hdr;
        pcm_addr_t  start;
        pcm_addr_t  exp_addr;
        logic [7:0] b;
        int         len;
        int         rst_fails;
        int         level;
        int         x;
        int         avg;
        int         acc;
        int         out;
        int         exp_snd;
        bit         moved;
        fails = 0;
        @(posedge clk);
        #1;
        hdr = pcm_table_base + 16'(f1[t] * 2);
        start = f2[t][15:0];
        len = int'(f3[t]);
        mem[hdr] = start[7:0];
        mem[hdr + 16'd1] = start[15:8];
        for (int i = 0; i < len; i++) begin
            if (i == 0) begin
                b = f4[t][7:0];
            end else if (i == 1) begin
                b = f5[t][7:0];
            end else begin
                rng = xorshift(rng);
                b = (rng[7:0] == 8'd0) ? 8'h01 : rng[7:0];
            end
            mem[start + 16'(i)] = b;
        end
        mem[start + 16'(len)] = 8'h00;
        fm_en = 1'b0;
        psg_en = 1'b0;
        pcm_board = 1'b1;
        portb = 8'h00;
        // fresh reset clears the blocker average
        apply_reset(rst_fails);
        fails += rst_fails;
        last_addr = 16'd0;
        @(posedge clk);
        #1;
        portb = {2'b10, f1[t][5:0]};
        @(posedge clk);
        #1;
        portb = 8'h00;
        acc = 0;
        for (int n = 0; n < len + 4; n++) begin
            if (n == 0) exp_addr = hdr;
            else if (n == 1) exp_addr = hdr + 16'd1;
            else exp_addr = start + 16'(n - 2);
            wait_addr_move(moved);
            if (!moved) begin
                $display("%s: pcm_addr stopped moving, waiting for %h", names[t], exp_addr);
                fails++;
                break;
            end
            if (pcm_addr !== exp_addr) begin
                $display("ERR %s: pcm_addr expected %h, got %h", names[t], exp_addr, pcm_addr);
                fails++;
            end
            if (n >= 3) begin
                // byte consumed on this step
                level = (mem[exp_addr - 16'd1] == 8'd0) ? int'(pcm_idle_level)
                                                          : int'(mem[exp_addr - 16'd1]);
                x = level - int'(pcm_idle_level);
                avg = acc >>> dc_shift;
                out = x - avg;
                if (out > 127) out = 127;
                if (out < -128) out = -128;
                acc = acc + x - avg;
                exp_snd = ((out * 256) * int'(gain_pcm)) >>> gain_shift;
                repeat (12) @(negedge clk);
                if (snd !== exp_snd[15:0]) begin
                    $display("ERR %s: snd expected %h, got %h", names[t], exp_snd[15:0], snd);
                    fails++;
                end
            end
        end
        if (pcm_addr !== e1[t][15:0]) begin
            $display("ERR %s: final pcm_addr expected %h, got %h", names[t], e1[t][15:0],
                     pcm_addr);
            fails++;
        end
        // an idle player leaves the address alone over several steps
        wait_addr_move(moved);
        if (moved) begin
            $display("%s: player kept reading after the end marker", names[t]);
            fails++;
        end
    endtask

    initial begin
        int    fd;
        int    cnt;
        int    fails;
        int    total_fails;
        int    failed_tests;
        longint max_ns;
        string line;
        string nm;
        string kd;
        logic [31:0] v [8];
        comb_rstn = 1'b0;
        sample = 1'b0;
        mix_cen = 1'b0;
        portb = 8'h00;
        pcm_ok = 1'b1;
        fm_snd = '0;
        psg_snd = 10'h200;
        fx_level = 2'd0;
        fm_en = 1'b0;
        psg_en = 1'b0;
        pcm_board = 1'b0;
        total_fails = 0;
        failed_tests = 0;
        max_ns = 2000;
        for (int a = 0; a < 65536; a++) begin
            mem[a] = 8'h5a ^ a[15:8] ^ a[7:0];
        end
        fd = $fopen("tests/snd_tests.txt", "r");
        if (fd == 0) begin
            $display("cannot open tests/snd_tests.txt");
            total_fails++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line[0] != "#") begin
                    cnt = $sscanf(line, "%s %s %h %h %h %h %h %h %h %h", nm, kd,
                                  v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7]);
                    if (cnt == 10) begin
                        names.push_back(nm);
                        kinds.push_back(kd);
                        f1.push_back(v[0]);
                        f2.push_back(v[1]);
                        f3.push_back(v[2]);
                        f4.push_back(v[3]);
                        f5.push_back(v[4]);
                        f6.push_back(v[5]);
                        e1.push_back(v[6]);
                        e2.push_back(v[7]);
                        if (kd == "play" && (longint'(v[2]) + 6) * 6000 > max_ns) begin
                            max_ns = (longint'(v[2]) + 6) * 6000;
                        end
                    end else begin
                        $display("malformed line in tests file: %s", line);
                        total_fails++;
                    end
                end
            end
            $fclose(fd);
        end
        limit_ns = longint'(names.size() + 1) * max_ns * 2;
        for (int t = 0; t < names.size(); t++) begin
            fails = 0;
            if (kinds[t] == "reset") reset_state(t, fails);
            else if (kinds[t] == "mix") mix_levels(t, fails);
            else if (kinds[t] == "play") sample_playback(t, fails);
            else begin
                $display("%s: unknown test kind %s", names[t], kinds[t]);
                fails = 1;
            end
            if (fails == 0) begin
                $display("test %s passed", names[t]);
            end else begin
                $display("test %s failed with %0d errors", names[t], fails);
                failed_tests++;
            end
            total_fails += fails;
        end
        $display("tests run %0d, failed %0d, errors %0d", names.size(), failed_tests,
                 total_fails);
        if (total_fails == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // watchdog sized from the longest test
    initial begin
        wait (limit_ns > 0);
        #(limit_ns);
        $display("watchdog expired after %0d ns, run stopped", limit_ns);
        $display("Done: errors found");
        $finish;
    end

endmodule

// ==== tests/snd_tests.txt ====
# name kind f1 f2 f3 f4 f5 f6 exp1 exp2, all numbers hex
# mix: fm psg fx_level fm_en psg_en pcm_board, exp1 snd, exp2 peak
# play: index start length byte0 byte1 unused, exp1 final pcm_addr, exp2 unused
# reset: fields unused, exp1 snd, exp2 peak
reset_defaults reset 0 0 0 0 0 0 0000 0
fm_std mix 1000 200 0 1 0 0 3000 0
fm_pcm_board mix 1000 200 0 1 0 1 2000 0
fm_disabled mix 1000 200 0 0 0 0 0000 0
fm_negative mix f000 200 0 1 0 0 d000 0
psg_level0 mix 0 280 0 0 1 0 0400 0
psg_level1 mix 0 280 1 0 1 0 0a00 0
psg_level2 mix 0 280 2 0 1 0 0e00 0
psg_level3 mix 0 280 3 0 1 0 1200 0
psg_negative mix 0 100 3 0 1 0 dc00 0
psg_disabled mix 0 280 3 0 0 0 0000 0
sat_positive mix 7fff 3ff 3 1 1 0 7fff 1
sat_recover mix 1000 200 3 1 1 0 3000 0
sat_negative mix 8000 000 3 1 1 0 8000 1
sat_recover2 mix f000 200 0 1 1 0 d000 0
play_idx0 play 0 1000 6 c0 40 0 1007 0
play_idx5 play 5 2340 4 ff 01 0 2345 0
play_idx3f play 3f 0400 a 80 a0 0 040b 0
